//--- ialu_top.f
ialu_pkg.sv
ialu_adder.sv
ialu_sqrt.sv
ialu_serial_mul.sv
ialu_ctrl.sv
ialu_top.sv
tb_ialu_assertions.sv
tb_ialu.sv

//--- Makefile
# Verilator build and run of the integer ALU testbench

TOP := tb_ialu

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f ialu_top.f --Mdir obj_dir

run: compile
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Test failed" sim.log; then exit 1; fi
	@grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb_ialu.sv
// Directed testbench for the integer ALU top level
// Each command group runs as a task and is checked against reference models

`timescale 1ns/1ps

module tb_ialu;
    import ialu_pkg::*;

    logic       clk;
    logic       rst_n;
    logic       ialu_vd;
    ialu_req_s  ialu_req;
    ialu_word_t ialu_res;
    logic       ialu_cmp;
    logic       ialu_rdy;
    int         err_count;
    int         timeout_count;

    ialu_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;             // 8 ns period
    end

    // --------------------
    // Compare tasks
    task automatic check_word(input string name, input ialu_word_t exp, input ialu_word_t act);
        if (act !== exp) begin
            err_count++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_cmp(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            err_count++;
            $display("** Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // One request; waited counts the cycles spent with ready low
    task automatic issue(input ialu_cmd_e cmd, input ialu_word_t a, input ialu_word_t b,
                         output ialu_word_t res, output logic cmp, output int waited);
        @(posedge clk);
        #1;
        ialu_vd  = 1'b1;
        ialu_req = '{op1: a, op2: b, cmd: cmd};
        waited   = 0;
        @(negedge clk);
        while (!ialu_rdy && waited < 100) begin
            waited++;
            @(negedge clk);
        end
        if (!ialu_rdy) begin
            timeout_count++;
            $display("Timeout: ready did not rise within 100 cycles for %s", cmd.name());
        end
        res = ialu_res;
        cmp = ialu_cmp;
        @(posedge clk);
        #1;
        ialu_vd = 1'b0;
    endtask

    task automatic run_comb(input string name, input ialu_cmd_e cmd, input ialu_word_t a,
                            input ialu_word_t b, input ialu_word_t exp, input logic exp_cmp);
        ialu_word_t res;
        logic       cmp;
        int         waited;
        issue(cmd, a, b, res, cmp, waited);
        check_word(name, exp, res);
        check_cmp({name, " cmp"}, exp_cmp, cmp);
        check_cmp({name, " same-cycle ready"}, 1'b1, waited == 0);
    endtask

    // Reference product from the 64-bit extended operands
    task automatic run_mul(input string name, input ialu_cmd_e cmd, input ialu_word_t a,
                           input ialu_word_t b);
        logic [63:0] x;
        logic [63:0] y;
        logic [63:0] p;
        ialu_word_t  res;
        logic        cmp;
        int          waited;
        x = (cmd == ialu_cmd_mulhu) ? {32'b0, a} : {{32{a[31]}}, a};
        y = (cmd == ialu_cmd_mul || cmd == ialu_cmd_mulh) ? {{32{b[31]}}, b} : {32'b0, b};
        p = x * y;
        issue(cmd, a, b, res, cmp, waited);
        check_word(name, (cmd == ialu_cmd_mul) ? p[31:0] : p[63:32], res);
        check_cmp({name, " cmp"}, 1'b0, cmp);
        check_cmp({name, " first-cycle ready"}, (a == 0) || (b == 0), waited == 0);
    endtask

    // --------------------
    // Tests
    task automatic test_logic_arith();
        ialu_word_t dir_a[3] = '{32'hFFFF_FFFF, 32'h0000_0000, 32'h8000_0000};
        ialu_word_t dir_b[3] = '{32'h0000_0001, 32'h0000_0001, 32'h8000_0000};
        ialu_word_t a;
        ialu_word_t b;
        for (int i = 0; i < 8; i++) begin
            if (i < 3) begin
                a = dir_a[i];
                b = dir_b[i];
            end else begin
                a = $urandom;
                b = $urandom;
            end
            run_comb("logic and", ialu_cmd_and, a, b, a & b, 1'b0);
            run_comb("logic or", ialu_cmd_or, a, b, a | b, 1'b0);
            run_comb("logic xor", ialu_cmd_xor, a, b, a ^ b, 1'b0);
            run_comb("arith add", ialu_cmd_add, a, b, a + b, 1'b0);
            run_comb("arith sub", ialu_cmd_sub, a, b, a - b, 1'b0);
        end
    endtask

    task automatic test_compare();
        ialu_word_t pa[5] = '{32'd5, 32'h8000_0000, 32'd0, 32'hFFFF_FFFF, 32'd1};
        ialu_word_t pb[5] = '{32'd5, 32'd0, 32'h8000_0000, 32'd1, 32'hFFFF_FFFF};
        logic       slt;
        logic       ult;
        logic       eq;
        for (int i = 0; i < 5; i++) begin
            slt = $signed(pa[i]) < $signed(pb[i]);
            ult = pa[i] < pb[i];
            eq  = pa[i] == pb[i];
            run_comb("cmp lt", ialu_cmd_sub_lt, pa[i], pb[i], ialu_word_t'(slt), slt);
            run_comb("cmp ltu", ialu_cmd_sub_ltu, pa[i], pb[i], ialu_word_t'(ult), ult);
            run_comb("cmp eq", ialu_cmd_sub_eq, pa[i], pb[i], ialu_word_t'(eq), eq);
            run_comb("cmp ne", ialu_cmd_sub_ne, pa[i], pb[i], ialu_word_t'(!eq), !eq);
            run_comb("cmp ge", ialu_cmd_sub_ge, pa[i], pb[i], ialu_word_t'(!slt), !slt);
            run_comb("cmp geu", ialu_cmd_sub_geu, pa[i], pb[i], ialu_word_t'(!ult), !ult);
        end
    endtask

    task automatic test_shift();
        ialu_word_t  sa[4] = '{32'h8000_0001, 32'h7654_3210, 32'hF0F0_0F0F, 32'h0000_0001};
        ialu_word_t  sb[4] = '{32'hFFFF_FFE4, 32'd31, 32'd0, 32'h0000_0125};
        logic [63:0] ext;
        for (int i = 0; i < 4; i++) begin
            ext = {{32{sa[i][31]}}, sa[i]} >> sb[i][4:0];   // Sign fill from the upper word
            run_comb("shift sll", ialu_cmd_sll, sa[i], sb[i], sa[i] << sb[i][4:0], 1'b0);
            run_comb("shift srl", ialu_cmd_srl, sa[i], sb[i], sa[i] >> sb[i][4:0], 1'b0);
            run_comb("shift sra", ialu_cmd_sra, sa[i], sb[i], ext[31:0], 1'b0);
        end
    endtask

    task automatic test_sqrt();
        ialu_word_t qa[11] = '{32'd0, 32'd1, 32'd15, 32'd16, 32'd17, 32'd999_999,
                               32'd1_000_000, 32'd1_000_001, 32'hFFFE_0000,
                               32'hFFFE_0001, 32'hFFFF_FFFF};
        ialu_word_t qe[11] = '{32'd0, 32'd1, 32'd3, 32'd4, 32'd4, 32'd999, 32'd1000,
                               32'd1000, 32'd65534, 32'd65535, 32'd65535};
        for (int i = 0; i < 11; i++) begin
            run_comb("sqrt", ialu_cmd_sqrt, qa[i], 32'h0, qe[i], 1'b0);
        end
    endtask

    task automatic test_mul();
        ialu_word_t ma[6] = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF,
                              32'h0, 32'h1234};
        ialu_word_t mb[6] = '{32'h8000_0000, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h8000_0000,
                              32'h1234, 32'h0};
        ialu_word_t a;
        ialu_word_t b;
        for (int i = 0; i < 10; i++) begin
            if (i < 6) begin
                a = ma[i];
                b = mb[i];
            end else begin
                a = $urandom;
                b = $urandom;
            end
            run_mul("mul", ialu_cmd_mul, a, b);
            run_mul("mulh", ialu_cmd_mulh, a, b);
            run_mul("mulhsu", ialu_cmd_mulhsu, a, b);
            run_mul("mulhu", ialu_cmd_mulhu, a, b);
        end
    endtask

    task automatic test_abort();
        @(posedge clk);
        #1;
        ialu_vd  = 1'b1;
        ialu_req = '{op1: 32'h9ABC_DEF1, op2: 32'h1357_9BDF, cmd: ialu_cmd_mulh};
        repeat (10) @(negedge clk);
        check_cmp("abort ready low midway", 1'b0, ialu_rdy);
        @(posedge clk);
        #1;
        ialu_vd = 1'b0;                   // Drop the request mid-operation
        run_mul("mulh after abort", ialu_cmd_mulh, 32'hFEDC_BA98, $urandom | 32'h1);
        run_mul("mulhu after abort", ialu_cmd_mulhu, $urandom | 32'h1, 32'h8765_4321);
    endtask

    // --------------------
    // Main sequence
    initial begin
        void'($urandom(88));
        rst_n         = 1'b0;
        ialu_vd       = 1'b0;
        ialu_req      = '{op1: '0, op2: '0, cmd: ialu_cmd_and};
        err_count     = 0;
        timeout_count = 0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_cmp("ready idle after reset", 1'b1, ialu_rdy);
        test_logic_arith();
        test_compare();
        test_shift();
        test_sqrt();
        test_mul();
        test_abort();
        $display("Checks done: %0d value errors, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- tb_ialu_assertions.sv
// Multiplier FSM assertions, bound into every ialu_serial_mul instance
// Checks a known state, ready timing over the iterations and the idle hold

`timescale 1ns/1ps

module tb_ialu_assertions (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      mul_vd,
    input logic                      mul_rdy,
    input ialu_pkg::ialu_mul_state_e state
);
    import ialu_pkg::*;

    logic [ialu_mul_cnt_w-1:0] iter_seen;   // ITER cycles since leaving idle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iter_seen <= '0;
        end else if (state == ialu_mul_iter) begin
            iter_seen <= iter_seen + 1'b1;
        end else begin
            iter_seen <= '0;
        end
    end

    a_state_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(state))
        else $error("multiplier state is unknown");

    // Idle step takes op2 bit 0, so ITER ends on its xlen-1 th cycle
    a_rdy_low_iter: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ialu_mul_iter && mul_vd)
            |-> (mul_rdy == (iter_seen == ialu_mul_cnt_w'(ialu_xlen - 2))))
        else $error("multiplier ready does not match the final iteration");

    a_idle_stays: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ialu_mul_idle && !mul_vd) |=> (state == ialu_mul_idle))
        else $error("multiplier left idle without a request");

endmodule

bind ialu_serial_mul tb_ialu_assertions i_mul_assert (
    .clk     (clk),
    .rst_n   (rst_n),
    .mul_vd  (mul_vd),
    .mul_rdy (mul_rdy),
    .state   (state)
);

//--- ialu_top.sv
// Top level of the integer ALU
// Takes a request with ialu_vd and returns result, compare flag and ready
// Non-multiply commands finish in the same cycle

`timescale 1ns/1ps

module ialu_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ialu_vd,
    input  ialu_pkg::ialu_req_s  ialu_req,
    output ialu_pkg::ialu_word_t ialu_res,
    output logic                 ialu_cmp,
    output logic                 ialu_rdy
);
    import ialu_pkg::*;

    logic           sum_sub;
    ialu_word_t     sum_res;
    ialu_flags_s    sum_flags;
    ialu_word_t     sqrt_res;
    logic           mul_vd;
    ialu_mul_kind_s mul_kind;
    ialu_word_t     mul_res;

    ialu_ctrl u_ctrl (
        .ialu_vd   (ialu_vd),
        .ialu_req  (ialu_req),
        .sum_res   (sum_res),
        .sum_flags (sum_flags),
        .sqrt_res  (sqrt_res),
        .mul_res   (mul_res),
        .sum_sub   (sum_sub),
        .mul_vd    (mul_vd),
        .mul_kind  (mul_kind),
        .ialu_res  (ialu_res),
        .ialu_cmp  (ialu_cmp)
    );

    ialu_adder u_adder (
        .op1       (ialu_req.op1),
        .op2       (ialu_req.op2),
        .sum_sub   (sum_sub),
        .sum_res   (sum_res),
        .sum_flags (sum_flags)
    );

    ialu_sqrt u_sqrt (
        .op1       (ialu_req.op1),
        .sqrt_res  (sqrt_res)
    );

    // Ready stays high here unless a multiply is iterating
    ialu_serial_mul u_mul (
        .clk       (clk),
        .rst_n     (rst_n),
        .mul_vd    (mul_vd),
        .mul_kind  (mul_kind),
        .op1       (ialu_req.op1),
        .op2       (ialu_req.op2),
        .mul_res   (mul_res),
        .mul_rdy   (ialu_rdy)
    );

endmodule

//--- ialu_ctrl.sv
// Command decode and result selection of the ALU
// Computes logic ops and shifts locally and forms compares from the adder flags

`timescale 1ns/1ps

module ialu_ctrl (
    input  logic                     ialu_vd,
    input  ialu_pkg::ialu_req_s      ialu_req,
    input  ialu_pkg::ialu_word_t     sum_res,
    input  ialu_pkg::ialu_flags_s    sum_flags,
    input  ialu_pkg::ialu_word_t     sqrt_res,
    input  ialu_pkg::ialu_word_t     mul_res,
    output logic                     sum_sub,
    output logic                     mul_vd,
    output ialu_pkg::ialu_mul_kind_s mul_kind,
    output ialu_pkg::ialu_word_t     ialu_res,
    output logic                     ialu_cmp
);
    import ialu_pkg::*;

    ialu_cmd_e               cmd;
    logic                    is_mul;
    logic                    lt;          // Signed less-than
    logic                    ltu;         // Unsigned less-than
    logic                    eq;
    logic                    cmp_bit;
    logic [ialu_shamt_w-1:0] shamt;

    assign cmd   = ialu_req.cmd;
    assign shamt = ialu_req.op2[ialu_shamt_w-1:0];

    // --------------------
    // Decode
    assign sum_sub = (cmd != ialu_cmd_add);
    assign is_mul  = (cmd == ialu_cmd_mul) | (cmd == ialu_cmd_mulh)
                   | (cmd == ialu_cmd_mulhsu) | (cmd == ialu_cmd_mulhu);
    assign mul_vd  = ialu_vd & is_mul;

    assign mul_kind.hi         = (cmd != ialu_cmd_mul);
    assign mul_kind.op1_signed = (cmd != ialu_cmd_mulhu);
    assign mul_kind.op2_signed = (cmd == ialu_cmd_mul) | (cmd == ialu_cmd_mulh);

    // --------------------
    // Compares
    assign lt  = sum_flags.s ^ sum_flags.o;
    assign ltu = sum_flags.c;
    assign eq  = sum_flags.z;

    always_comb begin
        case (cmd)
            ialu_cmd_sub_lt:  cmp_bit = lt;
            ialu_cmd_sub_ltu: cmp_bit = ltu;
            ialu_cmd_sub_eq:  cmp_bit = eq;
            ialu_cmd_sub_ne:  cmp_bit = ~eq;
            ialu_cmd_sub_ge:  cmp_bit = ~lt;
            ialu_cmd_sub_geu: cmp_bit = ~ltu;
            default:          cmp_bit = 1'b0;   // Low for non-compares
        endcase
    end

    assign ialu_cmp = cmp_bit;

    // --------------------
    // Result select
    always_comb begin
        ialu_res = '0;
        case (cmd)
            ialu_cmd_and: ialu_res = ialu_req.op1 & ialu_req.op2;
            ialu_cmd_or:  ialu_res = ialu_req.op1 | ialu_req.op2;
            ialu_cmd_xor: ialu_res = ialu_req.op1 ^ ialu_req.op2;
            ialu_cmd_add,
            ialu_cmd_sub: ialu_res = sum_res;
            ialu_cmd_sub_lt,
            ialu_cmd_sub_ltu,
            ialu_cmd_sub_eq,
            ialu_cmd_sub_ne,
            ialu_cmd_sub_ge,
            ialu_cmd_sub_geu: begin
                ialu_res = ialu_word_t'(cmp_bit);    // Flag in bit 0
            end
            ialu_cmd_sll: ialu_res = ialu_req.op1 << shamt;
            ialu_cmd_srl: ialu_res = ialu_req.op1 >> shamt;
            ialu_cmd_sra: ialu_res = $signed(ialu_req.op1) >>> shamt;
            ialu_cmd_sqrt: ialu_res = sqrt_res;
            ialu_cmd_mul,
            ialu_cmd_mulh,
            ialu_cmd_mulhsu,
            ialu_cmd_mulhu: ialu_res = mul_res;    // Valid only with ready
            default: ialu_res = '0;
        endcase
    end

endmodule

//--- ialu_serial_mul.sv
// Iterative shift-and-add multiplier, one bit of op2 per cycle
// Operands must stay stable while mul_vd is high; mul_rdy marks the result cycle
// Dropping mul_vd aborts the operation and returns the FSM to idle

`timescale 1ns/1ps

module ialu_serial_mul (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     mul_vd,
    input  ialu_pkg::ialu_mul_kind_s mul_kind,
    input  ialu_pkg::ialu_word_t     op1,
    input  ialu_pkg::ialu_word_t     op2,
    output ialu_pkg::ialu_word_t     mul_res,
    output logic                     mul_rdy
);
    import ialu_pkg::*;

    ialu_mul_state_e           state;
    ialu_mul_state_e           state_nxt;
    logic [ialu_mul_cnt_w-1:0] cnt;          // Remaining iterations
    logic [ialu_mul_cnt_w-1:0] cnt_nxt;
    logic                      cnt_borrow;
    logic                      iter_req;     // Start iterating from idle
    logic                      iter_last;    // Final step in ITER
    logic                      mul_bit;      // Current op2 bit
    logic                      step_sub;
    logic [ialu_xlen:0]        op1_ext;
    logic [ialu_xlen:0]        partial;
    logic [ialu_xlen:0]        acc_ext;
    logic [ialu_xlen:0]        step_sum;
    ialu_word_t                acc_hi;       // High product half
    ialu_word_t                acc_lo;       // Low product bits and unused op2 bits
    ialu_word_t                hi_nxt;
    ialu_word_t                lo_nxt;

    // --------------------
    // FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ialu_mul_idle;
        end else if (!mul_vd) begin
            state <= ialu_mul_idle;         // Abort on request drop
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ialu_mul_idle: begin
                if (iter_req) begin
                    state_nxt = ialu_mul_iter;
                end
            end
            ialu_mul_iter: begin
                if (iter_last) begin
                    state_nxt = ialu_mul_idle;
                end
            end
            default: state_nxt = ialu_mul_idle;
        endcase
    end

    // --------------------
    // Counter
    always_comb begin
        {cnt_borrow, cnt_nxt} = {1'b0, (state == ialu_mul_idle) ? ialu_mul_init_cnt : cnt} - 1'b1;
    end

    assign iter_req  = (|op1) & (|op2);      // Zero operand needs no iterations
    assign iter_last = (state == ialu_mul_iter) & cnt_borrow;

    // --------------------
    // Datapath step
    assign op1_ext  = {mul_kind.op1_signed & op1[ialu_xlen-1], op1};
    assign mul_bit  = (state == ialu_mul_idle) ? op2[0] : acc_lo[0];
    assign partial  = mul_bit ? op1_ext : '0;
    assign step_sub = mul_kind.op2_signed & iter_last;  // MSB of signed op2 weighs negative

    always_comb begin
        if (state == ialu_mul_idle) begin
            acc_ext = '0;
        end else begin
            acc_ext = {mul_kind.op1_signed & acc_hi[ialu_xlen-1], acc_hi};
        end
        step_sum = step_sub ? (acc_ext - partial) : (acc_ext + partial);
        hi_nxt   = step_sum[ialu_xlen:1];
        if (state == ialu_mul_idle) begin
            lo_nxt = {step_sum[0], op2[ialu_xlen-1:1]};
        end else begin
            lo_nxt = {step_sum[0], acc_lo[ialu_xlen-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (mul_vd & ~mul_rdy) begin
            cnt    <= cnt_nxt;
            acc_hi <= hi_nxt;
            acc_lo <= lo_nxt;
        end
    end

    // --------------------
    // Outputs
    assign mul_rdy = ~mul_vd | ((state == ialu_mul_idle) ? ~iter_req : iter_last);
    assign mul_res = (state == ialu_mul_iter) ? (mul_kind.hi ? hi_nxt : lo_nxt) : '0;

endmodule

//--- ialu_sqrt.sv
// Combinational integer square root of operand 1
// Root bits are resolved from the top down; the result is zero-extended

`timescale 1ns/1ps

module ialu_sqrt (
    input  ialu_pkg::ialu_word_t op1,
    output ialu_pkg::ialu_word_t sqrt_res
);
    import ialu_pkg::*;

    logic [ialu_sqrt_w-1:0] root;

    always_comb begin
        logic [ialu_sqrt_w-1:0] trial;     // Upper root bits with the tested bit set
        logic [ialu_xlen-1:0]   trial_sq;
        logic [ialu_xlen-1:0]   op1_top;   // Leading bits of op1 matching this trial

        root = '0;
        for (int i = ialu_sqrt_w - 1; i >= 0; i--) begin
            trial    = (root >> i) | ialu_sqrt_w'(1);
            trial_sq = ialu_xlen'(trial) * ialu_xlen'(trial);
            op1_top  = op1 >> (2 * i);
            if (trial_sq <= op1_top) begin
                root[i] = 1'b1;                // Keep bit while square fits
            end
        end
    end

    assign sqrt_res = ialu_word_t'(root);

endmodule

//--- ialu_adder.sv
// Main adder/subtractor of the ALU
// Also produces the flags that the compare commands are built from

`timescale 1ns/1ps

module ialu_adder (
    input  ialu_pkg::ialu_word_t  op1,
    input  ialu_pkg::ialu_word_t  op2,
    input  logic                  sum_sub,
    output ialu_pkg::ialu_word_t  sum_res,
    output ialu_pkg::ialu_flags_s sum_flags
);
    import ialu_pkg::*;

    logic [ialu_xlen:0] sum_ext;      // Result with carry bit on top

    always_comb begin
        if (sum_sub) begin
            sum_ext = {1'b0, op1} - {1'b0, op2};  // Borrow lands in the top bit
        end else begin
            sum_ext = {1'b0, op1} + {1'b0, op2};
        end
    end

    assign sum_res = sum_ext[ialu_xlen-1:0];

    // --------------------
    // Flags
    assign sum_flags.z = ~|sum_ext[ialu_xlen-1:0];
    assign sum_flags.s = sum_ext[ialu_xlen-1];
    assign sum_flags.c = sum_ext[ialu_xlen];

    // Overflow as seen by a subtraction, which is all compares use
    assign sum_flags.o = (~op1[ialu_xlen-1] &  op2[ialu_xlen-1] &  sum_ext[ialu_xlen-1])
                       | ( op1[ialu_xlen-1] & ~op2[ialu_xlen-1] & ~sum_ext[ialu_xlen-1]);

endmodule

//--- ialu_pkg.sv
// Shared widths, commands and bundles for the integer ALU
// Imported by every ALU module and by the testbench

package ialu_pkg;

    // --------------------
    // Widths and constants
    localparam int ialu_xlen      = 32;
    localparam int ialu_shamt_w   = 5;
    localparam int ialu_sqrt_w    = 16;
    localparam int ialu_mul_cnt_w = 5;
    localparam logic [ialu_mul_cnt_w-1:0] ialu_mul_init_cnt = ialu_mul_cnt_w'(ialu_xlen - 1);

    typedef logic [ialu_xlen-1:0] ialu_word_t;

    // --------------------
    // Commands
    typedef enum logic [4:0] {
        ialu_cmd_and,
        ialu_cmd_or,
        ialu_cmd_xor,
        ialu_cmd_add,
        ialu_cmd_sub,
        ialu_cmd_sub_lt,
        ialu_cmd_sub_ltu,
        ialu_cmd_sub_eq,
        ialu_cmd_sub_ne,
        ialu_cmd_sub_ge,
        ialu_cmd_sub_geu,
        ialu_cmd_sll,
        ialu_cmd_srl,
        ialu_cmd_sra,
        ialu_cmd_sqrt,
        ialu_cmd_mul,
        ialu_cmd_mulh,
        ialu_cmd_mulhsu,
        ialu_cmd_mulhu
    } ialu_cmd_e;

    typedef struct packed {
        ialu_word_t op1;
        ialu_word_t op2;
        ialu_cmd_e  cmd;
    } ialu_req_s;

    typedef struct packed {
        logic z;                // Result is zero
        logic s;                // Result sign
        logic o;                // Signed overflow
        logic c;                // Carry out, borrow on sub
    } ialu_flags_s;

    typedef struct packed {
        logic hi;               // High half of product
        logic op1_signed;
        logic op2_signed;
    } ialu_mul_kind_s;

    typedef enum logic {
        ialu_mul_idle,
        ialu_mul_iter
    } ialu_mul_state_e;

endpackage
